// ==== fpu_fmt_pkg.sv ====
/*
 * fpu format package
 * binary32 and 33-bit recoded layouts, exponent codes,
 * canonical NaN values in both forms
 */
`default_nettype none

package fpu_fmt_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned EXP_WIDTH = 8;
  // significand, hidden bit included
  localparam int unsigned SIG_WIDTH = 24;
  localparam int unsigned FRAC_WIDTH = SIG_WIDTH - 1;
  localparam int unsigned FP_WIDTH = EXP_WIDTH + SIG_WIDTH;
  localparam int unsigned REC_EXP_WIDTH = EXP_WIDTH + 1;

  // normal recoded exp is biased exp plus this offset
  localparam int unsigned REC_EXP_ADJ = (1 << (EXP_WIDTH - 1)) + 1;

  // top three bits of the recoded exponent
  localparam logic [2:0] REC_CODE_ZERO = 3'b000;
  localparam logic [2:0] REC_CODE_INF = 3'b110;
  localparam logic [2:0] REC_CODE_NAN = 3'b111;

  // --------------------
  // types
  // --------------------
  typedef logic [FP_WIDTH-1:0] fp32_t;
  typedef logic [EXP_WIDTH-1:0] fp_exp_t;
  typedef logic [FRAC_WIDTH-1:0] frac_t;
  typedef logic [REC_EXP_WIDTH-1:0] rec_exp_t;

  typedef struct packed {
    logic     sign;
    rec_exp_t exp;
    frac_t    frac;
  } rec_t;

  // quiet bit set, empty payload
  localparam fp32_t FP32_CANONICAL_NAN = 32'h7fc0_0000;
  localparam rec_t REC_CANONICAL_NAN = '{
    sign: 1'b0,
    exp:  {REC_CODE_NAN, {(REC_EXP_WIDTH - 3){1'b0}}},
    frac: {1'b1, {(FRAC_WIDTH - 1){1'b0}}}
  };

endpackage

`default_nettype wire

// ==== fpu_op_pkg.sv ====
/*
 * fpu operation package
 * op codes, request and response payloads, credit counts
 */
`default_nettype none

package fpu_op_pkg;

  // --------------------
  // operations
  // --------------------
  typedef enum logic [2:0] {
    FMIN = 3'd0,
    FMAX = 3'd1,
    FEQ  = 3'd2,
    FLT  = 3'd3,
    FLE  = 3'd4
  } fpu_op_e;

  // 67 bits
  typedef struct packed {
    fpu_op_e            op;
    fpu_fmt_pkg::fp32_t rs1;
    fpu_fmt_pkg::fp32_t rs2;
  } fpu_req_t;

  // 33 bits, compares return the flag in bit 0
  typedef struct packed {
    fpu_fmt_pkg::fp32_t result;
    logic               invalid;
  } fpu_resp_t;

  // --------------------
  // credits
  // --------------------
  typedef logic [2:0] fpu_cnt_t;

  // queue depth = upstream credits after reset
  localparam int unsigned REQ_CREDITS = 4;
  // downstream credits held after reset
  localparam fpu_cnt_t RESP_CREDITS = 3'd2;

endpackage

`default_nettype wire

// ==== fpu_recode.sv ====
/*
 * fpu_recode
 * binary32 to recoded form, subnormals normalized into the
 * extended exponent range, combinational
 */
`default_nettype none

module fpu_recode (
  input  fpu_fmt_pkg::fp32_t fp_i,
  output fpu_fmt_pkg::rec_t  rec_o
);
  import fpu_fmt_pkg::*;

  localparam int unsigned lz_width_lp = $clog2(FRAC_WIDTH);

  logic                   sign;
  fp_exp_t                exp_in;
  frac_t                  frac_in;
  logic                   exp_zero;
  logic                   exp_ones;
  logic                   frac_zero;
  logic [lz_width_lp-1:0] lz;
  frac_t                  norm_frac;
  rec_exp_t               sub_exp;
  rec_exp_t               norm_exp;

  // field split
  assign sign = fp_i[FP_WIDTH-1];
  assign exp_in = fp_i[FP_WIDTH-2 -: EXP_WIDTH];
  assign frac_in = fp_i[FRAC_WIDTH-1:0];

  assign exp_zero = (exp_in == '0);
  assign exp_ones = (exp_in == '1);
  assign frac_zero = (frac_in == '0);

  // leading zeros of the fraction
  // ascending scan, the highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i < FRAC_WIDTH; i++) begin
      if (frac_in[i]) begin
        lz = lz_width_lp'(FRAC_WIDTH - 1 - i);
      end
    end
  end

  // leading one shifted out, it becomes the hidden bit
  assign norm_frac = frac_t'(frac_in << (lz + 1));
  assign sub_exp = rec_exp_t'(REC_EXP_ADJ) - rec_exp_t'(lz);
  assign norm_exp = rec_exp_t'(exp_in) + rec_exp_t'(REC_EXP_ADJ);

  always_comb begin
    rec_o.sign = sign;
    rec_o.exp = norm_exp;
    rec_o.frac = frac_in;
    if (exp_ones) begin
      // inf drops its fraction, NaN keeps quiet bit and payload
      rec_o.exp = {frac_zero ? REC_CODE_INF : REC_CODE_NAN, {(REC_EXP_WIDTH - 3){1'b0}}};
    end else if (exp_zero && frac_zero) begin
      rec_o.exp = {REC_CODE_ZERO, {(REC_EXP_WIDTH - 3){1'b0}}};
    end else if (exp_zero) begin
      // subnormal
      rec_o.exp = sub_exp;
      rec_o.frac = norm_frac;
    end
  end

endmodule

`default_nettype wire

// ==== fpu_unrecode.sv ====
/*
 * fpu_unrecode
 * recoded form back to binary32, small exponents shifted
 * back into a subnormal fraction, combinational
 */
`default_nettype none

module fpu_unrecode (
  input  fpu_fmt_pkg::rec_t  rec_i,
  output fpu_fmt_pkg::fp32_t fp_o
);
  import fpu_fmt_pkg::*;

  localparam int unsigned sh_width_lp = $clog2(SIG_WIDTH);

  typedef logic [sh_width_lp-1:0] shamt_t;

  logic [2:0]           code;
  logic                 is_sub;
  shamt_t               sub_shift;
  logic [SIG_WIDTH-1:0] sub_sig;
  fp_exp_t              norm_exp;

  assign code = rec_i.exp[REC_EXP_WIDTH-1 -: 3];

  // exps up to REC_EXP_ADJ lie below the normal range
  assign is_sub = (rec_i.exp <= rec_exp_t'(REC_EXP_ADJ));

  // shift of 1 for the top subnormal binade, up to 23
  assign sub_shift = shamt_t'(rec_exp_t'(REC_EXP_ADJ + 1) - rec_i.exp);
  assign sub_sig = {1'b1, rec_i.frac} >> sub_shift;

  assign norm_exp = fp_exp_t'(rec_i.exp - rec_exp_t'(REC_EXP_ADJ));

  // --------------------
  // special codes first
  // --------------------
  always_comb begin
    fp_o = {rec_i.sign, norm_exp, rec_i.frac};
    if (code == REC_CODE_ZERO) begin
      fp_o = {rec_i.sign, {(FP_WIDTH - 1){1'b0}}};
    end else if (code == REC_CODE_INF) begin
      fp_o = {rec_i.sign, {EXP_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
    end else if (code == REC_CODE_NAN) begin
      // payload passes through untouched
      fp_o = {rec_i.sign, {EXP_WIDTH{1'b1}}, rec_i.frac};
    end else if (is_sub) begin
      fp_o = {rec_i.sign, {EXP_WIDTH{1'b0}}, sub_sig[FRAC_WIDTH-1:0]};
    end
  end

endmodule

`default_nettype wire

// ==== fpu_compare_rec.sv ====
/*
 * fpu_compare_rec
 * lt / eq compare of two recoded values, quiet or signaling,
 * unordered gives neither, combinational
 */
`default_nettype none

module fpu_compare_rec (
  input  fpu_fmt_pkg::rec_t a_i,
  input  fpu_fmt_pkg::rec_t b_i,
  input  logic              signaling_i,
  output logic              lt_o,
  output logic              eq_o,
  output logic              invalid_o
);
  import fpu_fmt_pkg::*;

  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic both_zero;
  logic unordered;
  logic mag_lt;
  logic mag_eq;
  logic ord_lt;
  logic ord_eq;

  // class decode from the exponent code
  assign a_nan = (a_i.exp[REC_EXP_WIDTH-1 -: 3] == REC_CODE_NAN);
  assign b_nan = (b_i.exp[REC_EXP_WIDTH-1 -: 3] == REC_CODE_NAN);
  // quiet bit is the fraction msb
  assign a_snan = a_nan & ~a_i.frac[FRAC_WIDTH-1];
  assign b_snan = b_nan & ~b_i.frac[FRAC_WIDTH-1];
  assign both_zero = (a_i.exp[REC_EXP_WIDTH-1 -: 3] == REC_CODE_ZERO)
                   & (b_i.exp[REC_EXP_WIDTH-1 -: 3] == REC_CODE_ZERO);
  assign unordered = a_nan | b_nan;

  // recoded exp and fraction order like the magnitude
  assign mag_lt = {a_i.exp, a_i.frac} < {b_i.exp, b_i.frac};
  assign mag_eq = {a_i.exp, a_i.frac} == {b_i.exp, b_i.frac};

  always_comb begin
    if (both_zero) begin
      ord_lt = 1'b0;
    end else if (a_i.sign != b_i.sign) begin
      // negative side is the smaller one
      ord_lt = a_i.sign;
    end else if (a_i.sign) begin
      ord_lt = ~mag_lt & ~mag_eq;
    end else begin
      ord_lt = mag_lt;
    end
  end

  // +0 and -0 compare equal
  assign ord_eq = both_zero | ((a_i.sign == b_i.sign) & mag_eq);

  assign lt_o = ord_lt & ~unordered;
  assign eq_o = ord_eq & ~unordered;
  assign invalid_o = a_snan | b_snan | (signaling_i & unordered);

endmodule

`default_nettype wire

// ==== fpu_fmin_fmax.sv ====
/*
 * fpu_fmin_fmax
 * min / max select on recoded operands with the NaN and
 * signed-zero rules, lt / eq come from the shared comparator
 */
`default_nettype none

module fpu_fmin_fmax (
  input  fpu_fmt_pkg::rec_t fp_rs1_i,
  input  fpu_fmt_pkg::rec_t fp_rs2_i,
  // 1 = FMIN, 0 = FMAX
  input  logic              fmin_not_fmax_i,
  input  logic              cmp_lt_i,
  input  logic              cmp_eq_i,
  output logic              invalid_o,
  output fpu_fmt_pkg::rec_t result_o
);
  import fpu_fmt_pkg::*;

  logic rs1_nan;
  logic rs2_nan;
  logic rs1_snan;
  logic rs2_snan;
  logic zero_diff_sign;
  logic pick_rs2;

  // --------------------
  // NaN detect
  // --------------------
  assign rs1_nan = (fp_rs1_i.exp[REC_EXP_WIDTH-1 -: 3] == REC_CODE_NAN);
  assign rs2_nan = (fp_rs2_i.exp[REC_EXP_WIDTH-1 -: 3] == REC_CODE_NAN);
  assign rs1_snan = rs1_nan & ~fp_rs1_i.frac[FRAC_WIDTH-1];
  assign rs2_snan = rs2_nan & ~fp_rs2_i.frac[FRAC_WIDTH-1];

  // equal with opposite signs happens only for +0 / -0
  assign zero_diff_sign = cmp_eq_i & (fp_rs1_i.sign ^ fp_rs2_i.sign);

  // --------------------
  // ordered select
  // --------------------
  always_comb begin
    if (zero_diff_sign) begin
      // min takes the negative zero, max the positive one
      pick_rs2 = fmin_not_fmax_i ^ fp_rs1_i.sign;
    end else begin
      // rs1 < rs2: min keeps rs1, max takes rs2
      pick_rs2 = cmp_lt_i ^ fmin_not_fmax_i;
    end
  end

  always_comb begin
    if (rs1_nan && rs2_nan) begin
      result_o = REC_CANONICAL_NAN;
    end else if (rs1_nan) begin
      result_o = fp_rs2_i;
    end else if (rs2_nan) begin
      result_o = fp_rs1_i;
    end else begin
      result_o = pick_rs2 ? fp_rs2_i : fp_rs1_i;
    end
  end

  // sNaN flags even when the result is a number
  assign invalid_o = rs1_snan | rs2_snan;

endmodule

`default_nettype wire

// ==== fpu_resp_fifo.sv ====
/*
 * fpu_resp_fifo
 * response queue, pops while it holds a downstream credit,
 * each pop hands one credit back upstream
 */
`default_nettype none

module fpu_resp_fifo #(
  parameter int unsigned depth_p = fpu_op_pkg::REQ_CREDITS
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  push_i,
  input  fpu_op_pkg::fpu_resp_t push_data_i,
  input  logic                  resp_credit_i,
  output logic                  resp_valid_o,
  output fpu_op_pkg::fpu_resp_t resp_o,
  output logic                  req_credit_o
);
  import fpu_op_pkg::*;

  localparam int unsigned ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int unsigned cnt_width_lp = $clog2(depth_p + 1);

  typedef logic [ptr_width_lp-1:0] ptr_t;
  typedef logic [cnt_width_lp-1:0] occ_t;

  fpu_resp_t mem [depth_p];
  ptr_t      wr_ptr_q;
  ptr_t      rd_ptr_q;
  occ_t      count_q;
  fpu_cnt_t  credit_q;
  logic      empty;
  logic      full;
  logic      wr_en;
  logic      pop;

  // wrap for any depth
  function automatic ptr_t ptr_inc(ptr_t p);
    return (p == ptr_t'(depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty = (count_q == '0);
  assign full = (count_q == occ_t'(depth_p));
  assign wr_en = push_i & ~full;
  // data must be in the queue and a slot free downstream
  assign pop = ~empty & (credit_q != '0);

  // --------------------
  // pointers and counters
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
      credit_q <= RESP_CREDITS;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({wr_en, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // spend on pop, refill on returned credit
      case ({pop, resp_credit_i})
        2'b10: credit_q <= credit_q - 1'b1;
        2'b01: credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign resp_valid_o = pop;
  assign resp_o = mem[rd_ptr_q];
  assign req_credit_o = pop;

endmodule

`default_nettype wire

// ==== fpu_minmax_top.sv ====
/*
 * fpu_minmax_top
 * fmin / fmax / feq / flt / fle on binary32 operands
 * recode stage, execute stage, credit-based response queue
 */
`default_nettype none

module fpu_minmax_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  input  fpu_op_pkg::fpu_req_t  req_i,
  output logic                  req_credit_o,
  output logic                  resp_valid_o,
  output fpu_op_pkg::fpu_resp_t resp_o,
  input  logic                  resp_credit_i
);
  import fpu_fmt_pkg::*;
  import fpu_op_pkg::*;

  typedef struct packed {
    fpu_op_e op;
    rec_t    rs1;
    rec_t    rs2;
  } recode_stage_t;

  recode_stage_t s1_d;
  recode_stage_t s1_q;
  logic          s1_valid_q;
  fpu_resp_t     s2_d;
  fpu_resp_t     s2_q;
  logic          s2_valid_q;

  logic          cmp_signaling;
  logic          cmp_lt;
  logic          cmp_eq;
  logic          cmp_invalid;
  logic          minmax_invalid;
  rec_t          minmax_rec;
  fp32_t         minmax_fp;

  // --------------------
  // stage 1, recode
  // --------------------
  assign s1_d.op = req_i.op;

  fpu_recode u_recode_rs1 (
    .fp_i  (req_i.rs1),
    .rec_o (s1_d.rs1)
  );

  fpu_recode u_recode_rs2 (
    .fp_i  (req_i.rs2),
    .rec_o (s1_d.rs2)
  );

  // --------------------
  // stage 2, execute
  // --------------------
  // flt / fle trap on any NaN
  assign cmp_signaling = (s1_q.op == FLT) | (s1_q.op == FLE);

  fpu_compare_rec u_compare (
    .a_i         (s1_q.rs1),
    .b_i         (s1_q.rs2),
    .signaling_i (cmp_signaling),
    .lt_o        (cmp_lt),
    .eq_o        (cmp_eq),
    .invalid_o   (cmp_invalid)
  );

  fpu_fmin_fmax u_fmin_fmax (
    .fp_rs1_i        (s1_q.rs1),
    .fp_rs2_i        (s1_q.rs2),
    .fmin_not_fmax_i (s1_q.op == FMIN),
    .cmp_lt_i        (cmp_lt),
    .cmp_eq_i        (cmp_eq),
    .invalid_o       (minmax_invalid),
    .result_o        (minmax_rec)
  );

  fpu_unrecode u_unrecode (
    .rec_i (minmax_rec),
    .fp_o  (minmax_fp)
  );

  // result and flag by op, compares return bit 0 only
  always_comb begin
    s2_d.result = '0;
    s2_d.invalid = cmp_invalid;
    case (s1_q.op)
      FMIN, FMAX: begin
        s2_d.result = minmax_fp;
        s2_d.invalid = minmax_invalid;
      end
      FEQ: s2_d.result[0] = cmp_eq;
      FLT: s2_d.result[0] = cmp_lt;
      FLE: s2_d.result[0] = cmp_lt | cmp_eq;
      default: s2_d.result = '0;
    endcase
  end

  // valid bits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // payload, loaded only with a valid beat
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      s1_q <= s1_d;
    end
    if (s1_valid_q) begin
      s2_q <= s2_d;
    end
  end

  // --------------------
  // response queue
  // --------------------
  // one slot per upstream credit, so the pipe never stalls
  fpu_resp_fifo #(
    .depth_p (REQ_CREDITS)
  ) u_resp_fifo (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (s2_valid_q),
    .push_data_i   (s2_q),
    .resp_credit_i (resp_credit_i),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .req_credit_o  (req_credit_o)
  );

endmodule

`default_nettype wire

// ==== tb_fpu_minmax_asserts.sv ====
/*
 * tb_fpu_minmax_asserts
 * credit and occupancy invariants of the response queue,
 * bound into fpu_resp_fifo
 */
`default_nettype none

module tb_fpu_minmax_asserts (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 push_i,
  input logic                 full_i,
  input fpu_op_pkg::fpu_cnt_t credit_i,
  input logic                 resp_credit_i,
  input logic                 resp_valid_i,
  input logic                 req_credit_i
);
  import fpu_op_pkg::*;

  // failures seen so far, read by the testbench
  int fail_cnt = 0;
  // downstream credits and queue fill as seen from the ports
  int port_credits;
  int port_occ;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      port_credits <= int'(RESP_CREDITS);
      port_occ <= 0;
    end else begin
      port_credits <= port_credits + int'(resp_credit_i) - int'(resp_valid_i);
      port_occ <= port_occ + int'(push_i) - int'(req_credit_i);
    end
  end

  // every beat in flight owns a slot
  push_not_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_i)
    else begin
      fail_cnt++;
      $error("push into a full response queue");
    end

  // a response always spends a held credit
  valid_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_i |-> (port_credits > 0))
    else begin
      fail_cnt++;
      $error("response sent with no downstream credit");
    end

  // upstream credit returns with each pop of a queued response
  credit_with_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_credit_i == (resp_valid_i && (port_occ > 0)))
    else begin
      fail_cnt++;
      $error("upstream credit pulse differs from a queued response leaving");
    end

  // receiver never returns more than it was given
  credit_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_i <= RESP_CREDITS)
    else begin
      fail_cnt++;
      $error("downstream credit count above its reset value");
    end

endmodule

`default_nettype wire

// ==== tb_fpu_minmax.sv ====
/*
 * tb_fpu_minmax
 * testbench for fpu_minmax_top: credit models on both sides,
 * IEEE reference model and an in-order response checker
 */
`default_nettype none

module tb_fpu_minmax;
  import fpu_fmt_pkg::*;
  import fpu_op_pkg::*;

  localparam int CLK_HALF = 2;
  localparam int RESET_CYC = 5;
  localparam logic [31:0] SEED = 32'h2cd50317;
  localparam int N_DIRECTED = 52;
  localparam int N_RANDOM = 400;
  localparam int N_BP = 12;
  localparam int N_BURST = 16;
  localparam int N_REQ = N_DIRECTED + N_RANDOM + N_BP + N_BURST + 1;
  localparam int TIMEOUT_CYC = 20 * N_REQ + 200;
  // drive edge to the edge that samples resp_valid_o
  localparam int FIRST_RESP_LAT = 4;
  localparam int BP_HOLD_CYC = 30;

  logic      clk_i;
  logic      rst_n_i;
  logic      req_valid_i;
  fpu_req_t  req_i;
  logic      req_credit_o;
  logic      resp_valid_o;
  fpu_resp_t resp_o;
  logic      resp_credit_i;

  int        cyc_cnt = 0;
  int        up_credits = 0;
  int        owed = 0;
  logic      hold_credits;
  logic      dn_random;
  int        sent_cnt;
  int        resp_cnt;
  int        issue_cyc;
  string     cur_test;
  fpu_resp_t exp_q[$];
  string     name_q[$];
  int        resp_cyc_q[$];

  fpu_minmax_top dut_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_credit_o  (req_credit_o),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .resp_credit_i (resp_credit_i)
  );

  bind fpu_resp_fifo tb_fpu_minmax_asserts u_fifo_asserts (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .push_i        (push_i),
    .full_i        (full),
    .credit_i      (credit_q),
    .resp_credit_i (resp_credit_i),
    .resp_valid_i  (resp_valid_o),
    .req_credit_i  (req_credit_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  // --------------------
  // compare and report
  // --------------------
  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s expected %h actual %h", name, exp_v, act_v);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // --------------------
  // reference model on IEEE bits
  // --------------------
  function automatic logic is_nan(input fp32_t x);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
  endfunction

  function automatic logic is_snan(input fp32_t x);
    return is_nan(x) && !x[22];
  endfunction

  function automatic logic is_zero(input fp32_t x);
    return x[30:0] == '0;
  endfunction

  // ordered a < b, zeros equal, NaNs kept out by the caller
  function automatic logic ieee_lt(input fp32_t a, input fp32_t b);
    if (is_zero(a) && is_zero(b)) return 1'b0;
    if (a[31] != b[31]) return a[31];
    // negative magnitudes order backwards
    if (a[31]) return a[30:0] > b[30:0];
    return a[30:0] < b[30:0];
  endfunction

  // min/max order, -0 below +0
  function automatic logic mm_lt(input fp32_t a, input fp32_t b);
    return ieee_lt(a, b) || (is_zero(a) && is_zero(b) && a[31] && !b[31]);
  endfunction

  function automatic fpu_resp_t ref_fpu(input fpu_op_e op, input fp32_t a, input fp32_t b);
    fpu_resp_t r;
    logic      unord;
    logic      lt;
    logic      eq;
    unord = is_nan(a) || is_nan(b);
    lt = !unord && ieee_lt(a, b);
    eq = !unord && ((is_zero(a) && is_zero(b)) || (a == b));
    r = '0;
    case (op)
      FMIN, FMAX: begin
        r.invalid = is_snan(a) || is_snan(b);
        if (is_nan(a) && is_nan(b)) r.result = FP32_CANONICAL_NAN;
        else if (is_nan(a)) r.result = b;
        else if (is_nan(b)) r.result = a;
        else if (op == FMIN) r.result = mm_lt(b, a) ? b : a;
        else r.result = mm_lt(a, b) ? b : a;
      end
      FEQ: begin
        r.result[0] = eq;
        r.invalid = is_snan(a) || is_snan(b);
      end
      FLT: begin
        r.result[0] = lt;
        r.invalid = unord;
      end
      default: begin
        r.result[0] = lt || eq;
        r.invalid = unord;
      end
    endcase
    return r;
  endfunction

  // operand drawn from a mix of classes
  function automatic fp32_t rand_operand();
    logic        sgn;
    logic [22:0] frac;
    fp32_t       v;
    sgn = 1'($urandom_range(0, 1));
    frac = 23'($urandom);
    case ($urandom_range(0, 7))
      0: v = {sgn, 8'h00, 23'h0};
      1: v = {sgn, 8'h00, frac | 23'h1};
      2: v = {sgn, 8'hff, 23'h0};
      3: v = {sgn, 8'hff, 1'b1, frac[21:0]};
      4: v = {sgn, 8'hff, 1'b0, frac[21:1], 1'b1};
      // edges of the normal range
      5: v = {sgn, ($urandom_range(0, 1) != 0) ? 8'h01 : 8'hfe, frac};
      default: v = {sgn, 8'($urandom_range(1, 254)), frac};
    endcase
    return v;
  endfunction

  // --------------------
  // credit models
  // --------------------
  // sender side, one credit per valid beat
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      up_credits <= REQ_CREDITS;
    end else begin
      up_credits <= up_credits + int'(req_credit_o) - int'(req_valid_i);
    end
  end

  // receiver side, returns one credit per response
  always @(posedge clk_i) begin : dn_model
    logic give;
    give = 1'b0;
    if (!rst_n_i) begin
      owed = 0;
    end else begin
      if (resp_valid_o) owed++;
      give = (owed > 0) && !hold_credits && (!dn_random || ($urandom_range(0, 2) == 0));
      if (give) owed--;
    end
    #1;
    resp_credit_i = give;
  end

  // cycle count and watchdog
  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("Error: timeout after %0d cycles with %0d responses still missing",
               cyc_cnt, exp_q.size());
      $display("Test failed");
      $fatal(1);
    end
  end

  // queue invariants from the bound checker
  always @(posedge clk_i) begin
    if (dut_i.u_resp_fifo.u_fifo_asserts.fail_cnt != 0) begin
      $display("Error: %0d assertion failures in the response queue",
               dut_i.u_resp_fifo.u_fifo_asserts.fail_cnt);
      $display("Test failed");
      $fatal(1);
    end
  end

  // in-order response check
  always @(posedge clk_i) begin : resp_check
    fpu_resp_t exp_r;
    string     name;
    if (rst_n_i && resp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Error: response arrived with no request outstanding");
        $display("Test failed");
        $fatal(1);
      end else begin
        exp_r = exp_q.pop_front();
        name = name_q.pop_front();
        check_value(name, 64'(exp_r), 64'(resp_o));
        resp_cnt++;
        // index of the current edge
        resp_cyc_q.push_back(cyc_cnt + 1);
      end
    end
  end

  // --------------------
  // stimulus helpers
  // --------------------
  // called one unit after an edge
  task automatic send_req(input fpu_op_e op, input fp32_t a, input fp32_t b);
    while (up_credits == 0) begin
      req_valid_i = 1'b0;
      @(posedge clk_i);
      #1;
    end
    req_valid_i = 1'b1;
    req_i.op = op;
    req_i.rs1 = a;
    req_i.rs2 = b;
    exp_q.push_back(ref_fpu(op, a, b));
    name_q.push_back($sformatf("%s %s %h %h", cur_test, op.name(), a, b));
    sent_cnt++;
    issue_cyc = cyc_cnt;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic minmax_pair(input fp32_t a, input fp32_t b);
    send_req(FMIN, a, b);
    send_req(FMAX, a, b);
  endtask

  task automatic cmp_triple(input fp32_t a, input fp32_t b);
    send_req(FEQ, a, b);
    send_req(FLT, a, b);
    send_req(FLE, a, b);
  endtask

  // queue empty, then time for the last credits to travel back
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
    repeat (3) @(posedge clk_i);
    #1;
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    int    bp_resp;
    int    bp_sent;
    int    resp_at_hold;
    int    sent_at_hold;
    fp32_t a;
    fp32_t b;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    resp_credit_i = 1'b0;
    hold_credits = 1'b0;
    dn_random = 1'b0;
    sent_cnt = 0;
    resp_cnt = 0;
    bp_resp = 0;
    bp_sent = 0;
    cur_test = "reset";
    void'($urandom(SEED));
    repeat (RESET_CYC) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_value("reset_state", 64'h0, 64'({req_credit_o, resp_valid_o}));

    // latency from an empty queue, then one response per cycle
    cur_test = "first_latency";
    resp_cyc_q.delete();
    send_req(FMAX, 32'h3f80_0000, 32'h4000_0000);
    wait_drain();
    check_value("first_latency", FIRST_RESP_LAT, resp_cyc_q[0] - issue_cyc);
    cur_test = "burst";
    resp_cyc_q.delete();
    for (int i = 0; i < N_BURST; i++) begin
      send_req(fpu_op_e'(i % 5), rand_operand(), rand_operand());
    end
    wait_drain();
    for (int i = 1; i < N_BURST; i++) begin
      check_value("burst_gap", 1, resp_cyc_q[i] - resp_cyc_q[i-1]);
    end

    cur_test = "directed_minmax";
    minmax_pair(32'h0000_0000, 32'h8000_0000);
    minmax_pair(32'h8000_0000, 32'h0000_0000);
    minmax_pair(32'h3f80_0000, 32'h3f80_0000);
    minmax_pair(32'h0000_0001, 32'h0040_0000);
    minmax_pair(32'h8000_0005, 32'h0000_0003);
    minmax_pair(32'h7f80_0000, 32'hff80_0000);
    minmax_pair(32'h7f80_0000, 32'h4049_0fdb);
    minmax_pair(32'hc000_0000, 32'h3f00_0000);
    minmax_pair(32'h3f80_0001, 32'h3f80_0000);
    wait_drain();

    // quiet, signaling and double NaN
    cur_test = "nan_minmax";
    minmax_pair(32'h7fc0_0001, 32'h3f80_0000);
    minmax_pair(32'h3f80_0000, 32'h7f80_0001);
    minmax_pair(32'hffa0_0000, 32'h8000_0000);
    minmax_pair(32'h7fc0_0000, 32'h7f80_0001);
    minmax_pair(32'hffc1_2345, 32'h7fc0_0000);
    wait_drain();

    cur_test = "compare";
    cmp_triple(32'h3f80_0000, 32'h4000_0000);
    cmp_triple(32'h4000_0000, 32'h3f80_0000);
    cmp_triple(32'h0000_0000, 32'h8000_0000);
    cmp_triple(32'h3f80_0000, 32'h3f80_0000);
    cmp_triple(32'h7fc0_0000, 32'h3f80_0000);
    cmp_triple(32'h7f80_0001, 32'h3f80_0000);
    cmp_triple(32'h0000_0001, 32'h0000_0002);
    cmp_triple(32'hff80_0000, 32'h8000_0001);
    wait_drain();

    // mixed classes, some equal pairs
    cur_test = "random";
    dn_random = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      a = rand_operand();
      b = ($urandom_range(0, 7) == 0) ? a : rand_operand();
      send_req(fpu_op_e'($urandom_range(0, 4)), a, b);
    end
    dn_random = 1'b0;
    wait_drain();

    // receiver withholds credits, sender must stall
    cur_test = "backpressure";
    resp_at_hold = resp_cnt;
    sent_at_hold = sent_cnt;
    hold_credits = 1'b1;
    fork
      begin
        for (int k = 0; k < N_BP; k++) begin
          send_req(fpu_op_e'($urandom_range(0, 4)), rand_operand(), rand_operand());
        end
      end
      begin
        repeat (BP_HOLD_CYC) @(posedge clk_i);
        #2;
        bp_resp = resp_cnt - resp_at_hold;
        bp_sent = sent_cnt - sent_at_hold;
        hold_credits = 1'b0;
      end
    join
    wait_drain();
    // only the credits held at the start may be spent
    check_value("bp_resp_during_hold", RESP_CREDITS, bp_resp);
    check_value("bp_sent_during_hold", REQ_CREDITS + RESP_CREDITS, bp_sent);
    // every response handed its upstream credit back
    check_value("up_credits_back", REQ_CREDITS, up_credits);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fpu_minmax.f ====
fpu_fmt_pkg.sv
fpu_op_pkg.sv
fpu_recode.sv
fpu_unrecode.sv
fpu_compare_rec.sv
fpu_fmin_fmax.sv
fpu_resp_fifo.sv
fpu_minmax_top.sv
tb_fpu_minmax_asserts.sv
tb_fpu_minmax.sv

// ==== Bender.yml ====
package:
  name: fpu_minmax

sources:
  # packages first, then leaf blocks, then the top level
  - fpu_fmt_pkg.sv
  - fpu_op_pkg.sv
  - fpu_recode.sv
  - fpu_unrecode.sv
  - fpu_compare_rec.sv
  - fpu_fmin_fmax.sv
  - fpu_resp_fifo.sv
  - fpu_minmax_top.sv
  - target: test
    files:
      - tb_fpu_minmax_asserts.sv
      - tb_fpu_minmax.sv
